//--- source/rv32_macros.svh
// RV32 memory stage widths
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Data and address width
`define XLEN 32

// Data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

//--- source/rv32_types_pkg.sv
// RV32 execute-side types
`include "rv32_macros.svh"

package rv32_types_pkg;

    // Memory operation carried with each execute record
    typedef enum logic [3:0] {
        MEM_NOP,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LBU,
        MEM_LHU,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } mem_op_t;

    // One buffered memory operation
    // For stores wb_result holds the data to write
    typedef struct packed {
        mem_op_t            mem_op;
        logic [`XLEN-1:0]   mem_addr;
        logic [`XLEN-1:0]   wb_result;
    } exec_buffer_data_t;

endpackage

//--- source/rv32_mem_pkg.sv
// RV32 data memory interface types
`include "rv32_macros.svh"

package rv32_mem_pkg;

    // Request from the load/store unit to the data memory
    typedef struct packed {
        logic [`XLEN-1:0]           addr;
        rv32_types_pkg::mem_op_t    op;
        logic [`XLEN-1:0]           data;
    } memory_request_t;

    // Response back toward the execute buffer
    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic               ready;
    } memory_response_t;

    // A memory word split into byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]    bytes;
        logic [1:0][15:0]   halves;
    } mem_word_u;

endpackage

//--- source/rv32_exec_buffer.sv
// Execute record buffer
`include "rv32_macros.svh"

module rv32_exec_buffer (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                exec_valid,
    input  rv32_types_pkg::exec_buffer_data_t   exec_data,
    input  rv32_mem_pkg::memory_response_t      response,
    output rv32_types_pkg::exec_buffer_data_t   exec_out,
    output logic                                busy,
    output logic                                wb_valid,
    output logic [`XLEN-1:0]                    wb_data
);

    rv32_types_pkg::mem_op_t    held_op;
    logic [`XLEN-1:0]           held_addr;
    logic [`XLEN-1:0]           held_data;
    logic                       capture;
    logic                       done;

    // New records are only taken while idle
    assign capture = exec_valid && !busy;
    assign done    = busy && response.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_op  <= rv32_types_pkg::MEM_NOP;
            busy     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= done;
            if (capture) begin
                held_op <= exec_data.mem_op;
                busy    <= 1'b1;
            end else if (done) begin
                // Back to idle so the memory sees no access
                held_op <= rv32_types_pkg::MEM_NOP;
                busy    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_addr <= exec_data.mem_addr;
            held_data <= exec_data.wb_result;
        end
    end

    // Result is taken in the same cycle ready is seen
    always_ff @(posedge clk) begin
        if (done) begin
            wb_data <= response.data;
        end
    end

    assign exec_out.mem_op    = held_op;
    assign exec_out.mem_addr  = held_addr;
    assign exec_out.wb_result = held_data;

endmodule

//--- source/rv32_load_store_unit.sv
// RV32 load/store unit
`include "rv32_macros.svh"

module rv32_load_store_unit (
    input  rv32_types_pkg::exec_buffer_data_t   exec_data,
    output rv32_mem_pkg::memory_response_t      response,
    // Data memory side
    output rv32_mem_pkg::memory_request_t       data_request,
    input  rv32_mem_pkg::memory_response_t      data_response
);

    rv32_mem_pkg::mem_word_u    load_word;
    logic [7:0]                 byte_lane;
    logic [15:0]                half_lane;

    always_comb begin
        data_request.addr = exec_data.mem_addr;
        data_request.op   = exec_data.mem_op;
        data_request.data = exec_data.wb_result;
    end

    // Lane selection from the low address bits
    always_comb begin
        load_word = data_response.data;
        byte_lane = load_word.bytes[exec_data.mem_addr[1:0]];
        // Odd half addresses read as zero
        if (exec_data.mem_addr[0]) begin
            half_lane = '0;
        end else begin
            half_lane = load_word.halves[exec_data.mem_addr[1]];
        end
    end

    // Sign or zero extension per load type
    always_comb begin
        response.ready = data_response.ready;
        case (exec_data.mem_op)
            rv32_types_pkg::MEM_LW: begin
                response.data = data_response.data;
            end
            rv32_types_pkg::MEM_LB: begin
                response.data = {{(`XLEN-8){byte_lane[7]}}, byte_lane};
            end
            rv32_types_pkg::MEM_LH: begin
                response.data = {{(`XLEN-16){half_lane[15]}}, half_lane};
            end
            rv32_types_pkg::MEM_LBU: begin
                response.data = {{(`XLEN-8){1'b0}}, byte_lane};
            end
            rv32_types_pkg::MEM_LHU: begin
                response.data = {{(`XLEN-16){1'b0}}, half_lane};
            end
            rv32_types_pkg::MEM_NOP: begin
                // Nothing to wait for
                response.ready = 1'b1;
                response.data  = '0;
            end
            default: begin
                // Stores write back zero
                response.data = '0;
            end
        endcase
    end

endmodule

//--- source/rv32_data_memory.sv
// Synchronous data memory
`include "rv32_macros.svh"

module rv32_data_memory (
    input  logic                            clk,
    input  logic                            arst_n,
    input  rv32_mem_pkg::memory_request_t   data_request,
    output rv32_mem_pkg::memory_response_t  data_response
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]           mem [`DMEM_WORDS];
    logic [IDX_W-1:0]           word_idx;
    logic                       access;
    logic                       is_store;
    logic                       ready;
    logic [`XLEN-1:0]           rd_data;
    rv32_mem_pkg::mem_word_u    cur_word;
    rv32_mem_pkg::mem_word_u    new_word;

    assign word_idx = data_request.addr[IDX_W+1:2];

    // One access per request, blocked while ready is still up
    assign access   = (data_request.op != rv32_types_pkg::MEM_NOP) && !ready;
    assign is_store = data_request.op inside {rv32_types_pkg::MEM_SB,
                                              rv32_types_pkg::MEM_SH,
                                              rv32_types_pkg::MEM_SW};

    // Merge store lanes into the current word
    always_comb begin
        cur_word = mem[word_idx];
        new_word = cur_word;
        case (data_request.op)
            rv32_types_pkg::MEM_SB: begin
                new_word.bytes[data_request.addr[1:0]] = data_request.data[7:0];
            end
            rv32_types_pkg::MEM_SH: begin
                new_word.halves[data_request.addr[1]] = data_request.data[15:0];
            end
            rv32_types_pkg::MEM_SW: begin
                new_word = data_request.data;
            end
            default: begin
                new_word = cur_word;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_data <= cur_word;
            if (is_store) begin
                mem[word_idx] <= new_word;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= access;
        end
    end

    assign data_response.data  = rd_data;
    assign data_response.ready = ready;

endmodule

//--- source/rv32_mem_stage.sv
// RV32 memory stage top
`include "rv32_macros.svh"

module rv32_mem_stage (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                exec_valid,
    input  rv32_types_pkg::exec_buffer_data_t   exec_data,
    output logic                                busy,
    output logic                                wb_valid,
    output logic [`XLEN-1:0]                    wb_data
);

    rv32_types_pkg::exec_buffer_data_t  exec_out;
    rv32_mem_pkg::memory_response_t     lsu_response;
    rv32_mem_pkg::memory_request_t      data_request;
    rv32_mem_pkg::memory_response_t     data_response;

    rv32_exec_buffer u_exec_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .exec_valid (exec_valid),
        .exec_data  (exec_data),
        .response   (lsu_response),
        .exec_out   (exec_out),
        .busy       (busy),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data)
    );

    rv32_load_store_unit u_load_store_unit (
        .exec_data     (exec_out),
        .response      (lsu_response),
        .data_request  (data_request),
        .data_response (data_response)
    );

    rv32_data_memory u_data_memory (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_request  (data_request),
        .data_response (data_response)
    );

endmodule

//--- verification/rv32_mem_stage_assertions.sv
// Memory stage timing and extension checks
`include "rv32_macros.svh"

module rv32_mem_stage_assertions (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                exec_valid,
    input  rv32_types_pkg::exec_buffer_data_t   exec_data,
    input  rv32_types_pkg::exec_buffer_data_t   exec_out,
    input  rv32_mem_pkg::memory_response_t      lsu_response,
    input  logic                                busy,
    input  logic                                wb_valid,
    input  logic [`XLEN-1:0]                    wb_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int     failures = 0;
    logic   accept_mem;
    logic   accept_nop;
    logic   done;

    assign accept_mem = exec_valid && !busy && (exec_data.mem_op != rv32_types_pkg::MEM_NOP);
    assign accept_nop = exec_valid && !busy && (exec_data.mem_op == rv32_types_pkg::MEM_NOP);
    assign done       = busy && lsu_response.ready;

    // Strobe rises after E+2 for memory ops, so it is sampled at E+3
    mem_latency: assert property (@(posedge clk) disable iff (!arst_n)
        accept_mem |-> ##3 wb_valid)
    else begin
        $error("write-back strobe missing two cycles after an accepted memory operation");
        failures++;
    end

    nop_latency: assert property (@(posedge clk) disable iff (!arst_n)
        accept_nop |-> ##2 wb_valid)
    else begin
        $error("write-back strobe missing one cycle after an accepted NOP");
        failures++;
    end

    single_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |=> !wb_valid)
    else begin
        $error("write-back strobe held high for two cycles");
        failures++;
    end

    // Result registered at the done edge is checked one cycle later
    lb_sign: assert property (@(posedge clk) disable iff (!arst_n)
        (done && exec_out.mem_op == rv32_types_pkg::MEM_LB)
        |=> wb_data[`XLEN-1:8] == {(`XLEN-8){wb_data[7]}})
    else begin
        $error("LB result is not sign extended");
        failures++;
    end

    lh_sign: assert property (@(posedge clk) disable iff (!arst_n)
        (done && exec_out.mem_op == rv32_types_pkg::MEM_LH)
        |=> wb_data[`XLEN-1:16] == {(`XLEN-16){wb_data[15]}})
    else begin
        $error("LH result is not sign extended");
        failures++;
    end

    lbu_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (done && exec_out.mem_op == rv32_types_pkg::MEM_LBU) |=> wb_data[`XLEN-1:8] == '0)
    else begin
        $error("LBU result is not zero extended");
        failures++;
    end

    lhu_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (done && exec_out.mem_op == rv32_types_pkg::MEM_LHU) |=> wb_data[`XLEN-1:16] == '0)
    else begin
        $error("LHU result is not zero extended");
        failures++;
    end

    reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy && !wb_valid)
    else begin
        $error("busy or write-back strobe high when reset was released");
        failures++;
    end

endmodule

bind rv32_mem_stage rv32_mem_stage_assertions u_checks (
    .clk          (clk),
    .arst_n       (arst_n),
    .exec_valid   (exec_valid),
    .exec_data    (exec_data),
    .exec_out     (exec_out),
    .lsu_response (lsu_response),
    .busy         (busy),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data)
);

//--- verification/rv32_mem_stage_tb.sv
// Memory stage testbench
`include "rv32_macros.svh"

module rv32_mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W       = $clog2(`DMEM_WORDS);
    localparam int ROUND_TRIPS = 300;
    // Roughly twice the cycles that all tests take
    localparam int CYCLE_LIMIT = 4000;

    logic                               clk;
    logic                               arst_n;
    logic                               exec_valid;
    rv32_types_pkg::exec_buffer_data_t  exec_data;
    logic                               busy;
    logic                               wb_valid;
    logic [`XLEN-1:0]                   wb_data;

    // Expected memory contents
    logic [`XLEN-1:0]   shadow [`DMEM_WORDS];
    logic [`XLEN-1:0]   known_addr;
    int                 cycles = 0;
    int                 errors = 0;
    int                 test_num = 0;
    int                 assert_base = 0;
    int                 tests_passed = 0;
    int                 tests_failed = 0;

    rv32_mem_stage DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .exec_valid (exec_valid),
        .exec_data  (exec_data),
        .busy       (busy),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] word_addr(input logic [IDX_W-1:0] idx);
        return 32'({idx, 2'b00});
    endfunction

    function automatic logic [31:0] expected_result(input rv32_types_pkg::mem_op_t op,
                                                    input logic [31:0] addr);
        logic [31:0]    word;
        logic [7:0]     b;
        logic [15:0]    h;
        word = shadow[addr[IDX_W+1:2]];
        b = 8'(word >> {addr[1:0], 3'b000});
        // Misaligned half loads read as zero
        h = addr[0] ? 16'h0000 : 16'(word >> {addr[1], 4'b0000});
        case (op)
            rv32_types_pkg::MEM_LW:  return word;
            rv32_types_pkg::MEM_LB:  return {{24{b[7]}}, b};
            rv32_types_pkg::MEM_LBU: return {24'h000000, b};
            rv32_types_pkg::MEM_LH:  return {{16{h[15]}}, h};
            rv32_types_pkg::MEM_LHU: return {16'h0000, h};
            default:                 return '0;
        endcase
    endfunction

    function automatic void store_shadow(input rv32_types_pkg::mem_op_t op,
                                         input logic [31:0] addr, input logic [31:0] data);
        logic [4:0]     shift;
        logic [31:0]    mask;
        case (op)
            rv32_types_pkg::MEM_SB: begin
                shift = {addr[1:0], 3'b000};
                mask  = 32'h0000_00ff;
            end
            rv32_types_pkg::MEM_SH: begin
                shift = {addr[1], 4'b0000};
                mask  = 32'h0000_ffff;
            end
            default: begin
                shift = '0;
                mask  = '1;
            end
        endcase
        mask = mask << shift;
        shadow[addr[IDX_W+1:2]] = (shadow[addr[IDX_W+1:2]] & ~mask) | ((data << shift) & mask);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic drive(input rv32_types_pkg::mem_op_t op, input logic [31:0] addr,
                         input logic [31:0] data);
        exec_valid          = 1'b1;
        exec_data.mem_op    = op;
        exec_data.mem_addr  = addr;
        exec_data.wb_result = data;
    endtask

    // Issues one operation with busy low and waits for its write-back
    task automatic run_op(input rv32_types_pkg::mem_op_t op, input logic [31:0] addr,
                          input logic [31:0] data, output int latency);
        logic [31:0]    expected;
        int             wanted;
        expected = expected_result(op, addr);
        wanted   = (op == rv32_types_pkg::MEM_NOP) ? 1 : 2;
        drive(op, addr, data);
        @(posedge clk);
        #1;
        exec_valid = 1'b0;
        latency = 0;
        while (!wb_valid && latency < 8) begin
            @(posedge clk);
            #1;
            latency++;
        end
        if (!wb_valid) begin
            $display("No write-back strobe for %s at %h within 8 cycles", op.name(), addr);
            errors++;
        end else begin
            check_value($sformatf("%s at %h result", op.name(), addr), wb_data, expected);
            check_value($sformatf("%s latency", op.name()), 32'(latency), 32'(wanted));
        end
        if (op inside {rv32_types_pkg::MEM_SB, rv32_types_pkg::MEM_SH, rv32_types_pkg::MEM_SW}) begin
            store_shadow(op, addr, data);
        end
    endtask

    task automatic start_test();
        test_num++;
        errors = 0;
        assert_base = DUT.u_checks.failures;
    endtask

    task automatic report_test(input string name);
        int fired;
        fired = DUT.u_checks.failures - assert_base;
        if (errors == 0 && fired == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED, %0d value errors, %0d assertion failures",
                     test_num, name, errors, fired);
        end
    endtask

    task automatic word_round_trip();
        logic [IDX_W-1:0]   idx;
        int                 i;
        int                 lat;
        start_test();
        for (i = 0; i < ROUND_TRIPS; i++) begin
            idx = IDX_W'($urandom);
            run_op(rv32_types_pkg::MEM_SW, word_addr(idx), $urandom, lat);
            run_op(rv32_types_pkg::MEM_LW, word_addr(idx), '0, lat);
        end
        known_addr = word_addr(idx);
        report_test("word round trip");
    endtask

    task automatic byte_lanes();
        logic [31:0]    addr;
        logic [31:0]    data;
        int             lane;
        int             lat;
        start_test();
        addr = word_addr(IDX_W'($urandom));
        for (lane = 0; lane < 4; lane++) begin
            data = $urandom;
            // Alternate the byte sign across lanes
            data[7] = lane[0];
            run_op(rv32_types_pkg::MEM_SB, addr | 32'(lane), data, lat);
        end
        run_op(rv32_types_pkg::MEM_LW, addr, '0, lat);
        for (lane = 0; lane < 4; lane++) begin
            run_op(rv32_types_pkg::MEM_LB, addr | 32'(lane), '0, lat);
            run_op(rv32_types_pkg::MEM_LBU, addr | 32'(lane), '0, lat);
        end
        report_test("byte lanes");
    endtask

    task automatic half_lanes();
        logic [31:0]    addr;
        logic [31:0]    data;
        int             off;
        int             lat;
        start_test();
        addr = word_addr(IDX_W'($urandom));
        data = $urandom;
        data[15] = 1'b1;
        run_op(rv32_types_pkg::MEM_SH, addr, data, lat);
        data = $urandom;
        data[15] = 1'b0;
        run_op(rv32_types_pkg::MEM_SH, addr | 32'd2, data, lat);
        for (off = 0; off < 4; off++) begin
            run_op(rv32_types_pkg::MEM_LH, addr | 32'(off), '0, lat);
            run_op(rv32_types_pkg::MEM_LHU, addr | 32'(off), '0, lat);
        end
        report_test("half lanes");
    endtask

    task automatic nop_timing();
        int lat_nop;
        int lat_lw;
        start_test();
        run_op(rv32_types_pkg::MEM_NOP, known_addr, $urandom, lat_nop);
        run_op(rv32_types_pkg::MEM_LW, known_addr, '0, lat_lw);
        check_value("NOP latency plus one", 32'(lat_nop + 1), 32'(lat_lw));
        report_test("NOP timing");
    endtask

    task automatic back_pressure();
        logic [IDX_W-1:0]   idx_b;
        logic [31:0]        addr_b;
        logic [31:0]        addr_c;
        logic [31:0]        expected;
        logic [31:0]        result;
        int                 strobes;
        int                 i;
        int                 lat;
        start_test();
        idx_b  = IDX_W'($urandom);
        addr_b = word_addr(idx_b);
        addr_c = word_addr(idx_b + IDX_W'(1));
        run_op(rv32_types_pkg::MEM_SW, addr_b, $urandom, lat);
        run_op(rv32_types_pkg::MEM_SW, addr_c, $urandom, lat);
        expected = expected_result(rv32_types_pkg::MEM_LW, addr_c);
        drive(rv32_types_pkg::MEM_LW, addr_c, '0);
        @(posedge clk);
        #1;
        strobes = 0;
        result  = '0;
        for (i = 0; i < 6; i++) begin
            // Stores offered only while the load is held
            if (busy && i[0]) begin
                drive(rv32_types_pkg::MEM_SB, addr_b, ~shadow[idx_b]);
            end else if (busy) begin
                drive(rv32_types_pkg::MEM_SW, addr_b, ~shadow[idx_b]);
            end else begin
                exec_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            if (wb_valid) begin
                strobes++;
                result = wb_data;
            end
        end
        exec_valid = 1'b0;
        check_value("write-back strobes under back-pressure", 32'(strobes), 32'd1);
        check_value("held load result", result, expected);
        run_op(rv32_types_pkg::MEM_LW, addr_b, '0, lat);
        report_test("back-pressure");
    endtask

    // Starts a load and pulls reset a given number of edges after it is taken
    task automatic reset_during_load(input logic [31:0] addr, input int edges);
        drive(rv32_types_pkg::MEM_LW, addr, '0);
        @(posedge clk);
        #1;
        exec_valid = 1'b0;
        repeat (edges) @(posedge clk);
        #1;
        arst_n = 1'b0;
        #1;
        check_value("busy during reset", {31'b0, busy}, '0);
        check_value("wb_valid during reset", {31'b0, wb_valid}, '0);
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic reset_mid_op();
        logic [31:0]    addr;
        int             lat;
        start_test();
        addr = word_addr(IDX_W'($urandom));
        run_op(rv32_types_pkg::MEM_SW, addr, $urandom, lat);
        // Reset while busy and memory ready are high
        reset_during_load(addr, 1);
        // Reset while the write-back strobe is high
        reset_during_load(addr, 2);
        run_op(rv32_types_pkg::MEM_LW, addr, '0, lat);
        report_test("reset in mid-operation");
    endtask

    initial begin
        void'($urandom(32'h9bdf));
        arst_n     = 1'b0;
        exec_valid = 1'b0;
        exec_data  = '0;
        known_addr = '0;
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            shadow[w] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        word_round_trip();
        byte_lanes();
        half_lanes();
        nop_timing();
        back_pressure();
        reset_mid_op();
        $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 tests_passed, tests_failed, DUT.u_checks.failures);
        if (tests_failed == 0 && DUT.u_checks.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/rv32_types_pkg.sv
source/rv32_mem_pkg.sv
source/rv32_exec_buffer.sv
source/rv32_load_store_unit.sv
source/rv32_data_memory.sv
source/rv32_mem_stage.sv
verification/rv32_mem_stage_assertions.sv
verification/rv32_mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f project.f \
    --top-module rv32_mem_stage_tb -o sim_rv32_mem_stage > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_rv32_mem_stage +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
